// ==== Bender.yml ====
package:
  name: ooo_backend

sources:
  - logic/core_cfg_pkg.sv
  - logic/core_bus_pkg.sv
  - logic/dispatch_ctrl.sv
  - logic/issue_queue.sv
  - logic/alu_unit.sv
  - logic/cdb_arbiter.sv
  - logic/rob.sv
  - logic/backend_top.sv
  - target: test
    files:
      - verification/backend_tb.sv

// ==== build.f ====
logic/core_cfg_pkg.sv
logic/core_bus_pkg.sv
logic/dispatch_ctrl.sv
logic/issue_queue.sv
logic/alu_unit.sv
logic/cdb_arbiter.sv
logic/rob.sv
logic/backend_top.sv
verification/backend_tb.sv

// ==== logic/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit
    import core_cfg_pkg::*;
    import core_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      valid_i,
    input  exec_req_t req_i,
    output logic      res_valid_o,
    output cdb_t      res_o
);

    logic [DATA_WIDTH-1:0] result;
    logic [DATA_WIDTH-1:0] data_q;
    rob_id_t               id_q;

    always_comb begin
        case (req_i.op)
            ALU_ADD: result = req_i.op_a + req_i.op_b;
            ALU_SUB: result = req_i.op_a - req_i.op_b;
            ALU_AND: result = req_i.op_a & req_i.op_b;
            ALU_OR:  result = req_i.op_a | req_i.op_b;
            ALU_XOR: result = req_i.op_a ^ req_i.op_b;
            ALU_SLT: result = DATA_WIDTH'($signed(req_i.op_a) < $signed(req_i.op_b));
            default: result = '0;  // unused encodings
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= valid_i;  // always accepts
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            data_q <= result;
            id_q   <= req_i.rob_id;
        end
    end

    assign res_o = '{valid: res_valid_o, rob_id: id_q, data: data_q};

endmodule

// ==== logic/backend_top.sv ====
`timescale 1ns/1ps

module backend_top
    import core_bus_pkg::*;
#(
    parameter int IQ_DEPTH       = 4,
    parameter int RES_FIFO_DEPTH = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  in_valid_i,
    input  instr_t                in_instr_i,
    output logic                  in_ready_o,
    output logic                  commit_valid_o,
    input  logic                  commit_ready_i,
    output rob_id_t               commit_rob_id_o,
    output logic [DATA_WIDTH-1:0] commit_data_o
);

    logic            alloc_valid;
    rob_id_t         alloc_id;
    logic            rob_full;
    rob_id_t         rob_tag_a;
    rob_id_t         rob_tag_b;
    rob_rd_t         rob_rd_a;
    rob_rd_t         rob_rd_b;
    logic [1:0]      iq_full;
    logic [1:0]      iq_wr;
    iq_entry_t       iq_entry;    // shared, iq_wr picks the queue
    logic [1:0]      issue_valid;
    exec_req_t [1:0] issue;
    logic [1:0]      res_valid;
    cdb_t [1:0]      res;
    logic [1:0]      fifo_full;
    cdb_t            cdb;         // single lane

    dispatch_ctrl i_dispatch (
        .clk_i, .rst_n_i, .in_valid_i, .in_instr_i, .in_ready_o,
        .rob_full_i(rob_full), .alloc_id_i(alloc_id), .alloc_valid_o(alloc_valid),
        .rob_tag_a_o(rob_tag_a), .rob_tag_b_o(rob_tag_b),
        .rob_rd_a_i(rob_rd_a), .rob_rd_b_i(rob_rd_b),
        .iq_full_i(iq_full), .iq_wr_o(iq_wr), .iq_entry_o(iq_entry), .cdb_i(cdb)
    );

    // one queue and alu per unit
    for (genvar u = 0; u < 2; u++) begin : g_alu
        issue_queue #(.IQ_DEPTH(IQ_DEPTH)) i_iq (
            .clk_i, .rst_n_i, .wr_i(iq_wr[u]), .entry_i(iq_entry), .cdb_i(cdb),
            .fifo_full_i(fifo_full[u]), .full_o(iq_full[u]),
            .issue_valid_o(issue_valid[u]), .issue_o(issue[u])
        );

        alu_unit i_alu (
            .clk_i, .rst_n_i, .valid_i(issue_valid[u]), .req_i(issue[u]),
            .res_valid_o(res_valid[u]), .res_o(res[u])
        );
    end

    cdb_arbiter #(.RES_FIFO_DEPTH(RES_FIFO_DEPTH)) i_cdb_arb (
        .clk_i, .rst_n_i, .res_valid_i(res_valid), .res_i(res),
        .fifo_full_o(fifo_full), .cdb_o(cdb)
    );

    rob i_rob (
        .clk_i, .rst_n_i, .alloc_valid_i(alloc_valid), .alloc_id_o(alloc_id),
        .full_o(rob_full), .cdb_i(cdb), .rd_tag_a_i(rob_tag_a), .rd_tag_b_i(rob_tag_b),
        .rd_a_o(rob_rd_a), .rd_b_o(rob_rd_b), .commit_valid_o, .commit_ready_i,
        .commit_rob_id_o, .commit_data_o
    );

endmodule

// ==== logic/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter
    import core_cfg_pkg::*;
    import core_bus_pkg::*;
#(
    parameter int RES_FIFO_DEPTH = 2
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic [1:0] res_valid_i,
    input  cdb_t [1:0] res_i,
    output logic [1:0] fifo_full_o,
    output cdb_t       cdb_o
);

    localparam int PW = (RES_FIFO_DEPTH > 1) ? $clog2(RES_FIFO_DEPTH) : 1;
    localparam int CW = $clog2(RES_FIFO_DEPTH + 1);

    cdb_t          mem_q [2][RES_FIFO_DEPTH];
    logic [PW-1:0] rd_ptr_q [2];
    logic [PW-1:0] wr_ptr_q [2];
    logic [CW-1:0] cnt_q [2];
    cdb_t          cand [2];   // fifo head, or the fresh result when empty
    logic [1:0]    cand_valid;
    logic [1:0]    grant;
    logic [1:0]    push;
    logic [1:0]    pop;
    logic          rr_q;       // unit with priority on a tie
    logic          cdb_valid_q;
    cdb_t          cdb_q;

    always_comb begin
        for (int u = 0; u < 2; u++) begin
            cand_valid[u] = (cnt_q[u] != '0) || res_valid_i[u];
            cand[u]       = (cnt_q[u] != '0) ? mem_q[u][rd_ptr_q[u]] : res_i[u];
        end
        grant[0] = cand_valid[0] && (!cand_valid[1] || !rr_q);
        grant[1] = cand_valid[1] && (!cand_valid[0] || rr_q);
        for (int u = 0; u < 2; u++) begin
            pop[u]  = grant[u] && (cnt_q[u] != '0);
            push[u] = res_valid_i[u] && !(grant[u] && cnt_q[u] == '0);  // bypass skips fifo
            // two results may still be in the issue and alu registers
            fifo_full_o[u] = (int'(cnt_q[u]) + int'(push[u]) + 1) >= RES_FIFO_DEPTH;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int u = 0; u < 2; u++) begin
                rd_ptr_q[u] <= '0;
                wr_ptr_q[u] <= '0;
                cnt_q[u]    <= '0;
            end
            rr_q        <= 1'b0;
            cdb_valid_q <= 1'b0;
        end else begin
            for (int u = 0; u < 2; u++) begin
                if (pop[u]) begin
                    rd_ptr_q[u] <= (rd_ptr_q[u] == PW'(RES_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q[u] + 1'b1;
                end
                if (push[u]) begin
                    wr_ptr_q[u] <= (wr_ptr_q[u] == PW'(RES_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q[u] + 1'b1;
                end
                cnt_q[u] <= cnt_q[u] + CW'(push[u]) - CW'(pop[u]);
            end
            if (grant[0]) rr_q <= 1'b1;  // pass priority to the other unit
            else if (grant[1]) rr_q <= 1'b0;
            cdb_valid_q <= |grant;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int u = 0; u < 2; u++) begin
            if (push[u]) mem_q[u][wr_ptr_q[u]] <= res_i[u];
        end
        if (|grant) cdb_q <= grant[1] ? cand[1] : cand[0];
    end

    assign cdb_o = '{valid: cdb_valid_q, rob_id: cdb_q.rob_id, data: cdb_q.data};

    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(grant))
        else $error("cdb grant not one-hot");

    for (genvar u = 0; u < 2; u++) begin : g_chk
        // credit from fifo_full_o must cover results already in flight
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            push[u] |-> (cnt_q[u] != CW'(RES_FIFO_DEPTH)) || pop[u])
            else $error("push into full result fifo %0d", u);
    end

endmodule

// ==== logic/core_bus_pkg.sv ====
package core_bus_pkg;

    import core_cfg_pkg::*;
    export core_cfg_pkg::*;  // rob_id_t and DATA_WIDTH visible to users of this package

    // source operand, literal when is_tag is low
    typedef struct packed {
        logic                  is_tag;
        rob_id_t               tag;
        logic [DATA_WIDTH-1:0] value;
    } src_t;

    typedef struct packed {
        alu_op_e op;
        src_t    src_a;
        src_t    src_b;
    } instr_t;

    // issue queue slot
    typedef struct packed {
        alu_op_e               op;
        rob_id_t               rob_id;
        logic                  a_rdy;
        rob_id_t               a_tag;
        logic [DATA_WIDTH-1:0] a_val;
        logic                  b_rdy;
        rob_id_t               b_tag;
        logic [DATA_WIDTH-1:0] b_val;
    } iq_entry_t;

    typedef struct packed {
        alu_op_e               op;
        rob_id_t               rob_id;
        logic [DATA_WIDTH-1:0] op_a;
        logic [DATA_WIDTH-1:0] op_b;
    } exec_req_t;

    typedef struct packed {
        logic                  valid;
        rob_id_t               rob_id;
        logic [DATA_WIDTH-1:0] data;
    } cdb_t;

    typedef struct packed {
        logic                  done;
        logic [DATA_WIDTH-1:0] value;
    } rob_rd_t;

endpackage

// ==== logic/core_cfg_pkg.sv ====
package core_cfg_pkg;

    localparam int DATA_WIDTH = 32;  // operand and result width
    localparam int ROB_DEPTH  = 8;   // power of two, pointers wrap on their own

    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_id_t;

    // alu opcodes
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,  // a - b
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5   // signed a < b, gives 1 or 0
    } alu_op_e;

endpackage

// ==== logic/dispatch_ctrl.sv ====
`timescale 1ns/1ps

module dispatch_ctrl
    import core_cfg_pkg::*;
    import core_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      in_valid_i,
    input  instr_t    in_instr_i,
    output logic      in_ready_o,
    input  logic      rob_full_i,
    input  rob_id_t   alloc_id_i,
    output logic      alloc_valid_o,
    output rob_id_t   rob_tag_a_o,
    output rob_id_t   rob_tag_b_o,
    input  rob_rd_t   rob_rd_a_i,
    input  rob_rd_t   rob_rd_b_i,
    input  logic[1:0] iq_full_i,
    output logic[1:0] iq_wr_o,
    output iq_entry_t iq_entry_o,
    input  cdb_t      cdb_i
);

    logic    accept;
    logic    to_q0;      // steer this instruction to queue 0
    logic    last_q0_q;  // previous instruction went to queue 0
    src_t    res_a;
    src_t    res_b;

    // literal, then finished rob entry, then live cdb; is_tag stays set if still waiting
    function automatic src_t resolve(src_t s, rob_rd_t rd, cdb_t cdb);
        src_t r;
        r = s;
        if (s.is_tag) begin
            if (rd.done) begin
                r.is_tag = 1'b0;
                r.value  = rd.value;
            end else if (cdb.valid && cdb.rob_id == s.tag) begin
                r.is_tag = 1'b0;
                r.value  = cdb.data;
            end
        end
        return r;
    endfunction

    assign in_ready_o    = !rob_full_i && !(&iq_full_i);
    assign accept        = in_valid_i && in_ready_o;
    assign alloc_valid_o = accept;

    assign rob_tag_a_o = in_instr_i.src_a.tag;  // combinational rob reads
    assign rob_tag_b_o = in_instr_i.src_b.tag;

    assign res_a = resolve(in_instr_i.src_a, rob_rd_a_i, cdb_i);
    assign res_b = resolve(in_instr_i.src_b, rob_rd_b_i, cdb_i);

    // alternate queues, fall back to queue 0 when queue 1 is full
    assign to_q0   = !iq_full_i[0] && (!last_q0_q || iq_full_i[1]);
    assign iq_wr_o = {accept && !to_q0, accept && to_q0};

    always_comb begin
        iq_entry_o.op     = in_instr_i.op;
        iq_entry_o.rob_id = alloc_id_i;
        iq_entry_o.a_rdy  = !res_a.is_tag;
        iq_entry_o.a_tag  = res_a.tag;
        iq_entry_o.a_val  = res_a.value;
        iq_entry_o.b_rdy  = !res_b.is_tag;
        iq_entry_o.b_tag  = res_b.tag;
        iq_entry_o.b_val  = res_b.value;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q0_q <= 1'b0;
        end else if (accept) begin
            last_q0_q <= to_q0;
        end
    end

    // steering must respect the full levels fed back by both queues
    assert property (@(posedge clk_i) disable iff (!rst_n_i) (iq_wr_o & iq_full_i) == 2'b00)
        else $error("dispatch wrote into a full issue queue");

endmodule

// ==== logic/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue
    import core_cfg_pkg::*;
    import core_bus_pkg::*;
#(
    parameter int IQ_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      wr_i,
    input  iq_entry_t entry_i,
    input  cdb_t      cdb_i,
    input  logic      fifo_full_i,
    output logic      full_o,
    output logic      issue_valid_o,
    output exec_req_t issue_o
);

    localparam int CW = $clog2(IQ_DEPTH + 1);

    iq_entry_t      q_q  [IQ_DEPTH];  // slot 0 is the oldest
    iq_entry_t      woke [IQ_DEPTH];
    iq_entry_t      q_d  [IQ_DEPTH];
    logic [CW-1:0]  cnt_q;
    logic [CW-1:0]  cnt_left;         // count after this cycle's issue
    logic           found;
    logic           do_issue;
    int             sel;

    assign full_o = (cnt_q == CW'(IQ_DEPTH));

    always_comb begin
        found = 1'b0;
        sel   = 0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            woke[i] = q_q[i];
            // cdb wakeup
            if (cdb_i.valid && !q_q[i].a_rdy && q_q[i].a_tag == cdb_i.rob_id) begin
                woke[i].a_rdy = 1'b1;
                woke[i].a_val = cdb_i.data;
            end
            if (cdb_i.valid && !q_q[i].b_rdy && q_q[i].b_tag == cdb_i.rob_id) begin
                woke[i].b_rdy = 1'b1;
                woke[i].b_val = cdb_i.data;
            end
            // oldest ready wins, registered ready bits only
            if (!found && i < int'(cnt_q) && q_q[i].a_rdy && q_q[i].b_rdy) begin
                found = 1'b1;
                sel   = i;
            end
        end
        do_issue = found && !fifo_full_i;  // hold while result fifo is full
        cnt_left = cnt_q - CW'(do_issue);
        // compact over the issued slot, then append the new entry
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (do_issue && i >= sel) begin
                q_d[i] = woke[(i + 1 < IQ_DEPTH) ? i + 1 : i];
            end else begin
                q_d[i] = woke[i];
            end
            if (wr_i && i == int'(cnt_left)) begin
                q_d[i] = entry_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q         <= '0;
            issue_valid_o <= 1'b0;
        end else begin
            cnt_q         <= cnt_left + CW'(wr_i);
            issue_valid_o <= do_issue;
        end
    end

    always_ff @(posedge clk_i) begin
        q_q <= q_d;  // slots past cnt_q are don't care
        if (do_issue) begin
            issue_o.op     <= q_q[sel].op;
            issue_o.rob_id <= q_q[sel].rob_id;
            issue_o.op_a   <= q_q[sel].a_val;
            issue_o.op_b   <= q_q[sel].b_val;
        end
    end

    // dispatch sees full_o a cycle late only if it ignores the level
    assert property (@(posedge clk_i) disable iff (!rst_n_i) wr_i |-> !full_o)
        else $error("issue queue written while full");

endmodule

// ==== logic/rob.sv ====
`timescale 1ns/1ps

module rob
    import core_cfg_pkg::*;
    import core_bus_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  alloc_valid_i,
    output rob_id_t               alloc_id_o,
    output logic                  full_o,
    input  cdb_t                  cdb_i,
    input  rob_id_t               rd_tag_a_i,
    input  rob_id_t               rd_tag_b_i,
    output rob_rd_t               rd_a_o,
    output rob_rd_t               rd_b_o,
    output logic                  commit_valid_o,
    input  logic                  commit_ready_i,
    output rob_id_t               commit_rob_id_o,
    output logic [DATA_WIDTH-1:0] commit_data_o
);

    localparam int PW = $bits(rob_id_t);

    rob_id_t               head_q;
    rob_id_t               tail_q;
    logic [PW:0]           cnt_q;
    logic [ROB_DEPTH-1:0]  done_q;
    logic [DATA_WIDTH-1:0] val_q [ROB_DEPTH];
    logic                  commit_fire;
    rob_id_t               cdb_off;  // distance of the cdb entry from head

    assign full_o     = (cnt_q == (PW+1)'(ROB_DEPTH));
    assign alloc_id_o = tail_q;

    // read ports, a committed entry keeps its value until reallocated
    assign rd_a_o = '{done: done_q[rd_tag_a_i], value: val_q[rd_tag_a_i]};
    assign rd_b_o = '{done: done_q[rd_tag_b_i], value: val_q[rd_tag_b_i]};

    assign commit_valid_o  = (cnt_q != '0) && done_q[head_q];
    assign commit_rob_id_o = head_q;
    assign commit_data_o   = val_q[head_q];
    assign commit_fire     = commit_valid_o && commit_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
            done_q <= '0;
        end else begin
            if (alloc_valid_i) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            if (cdb_i.valid) done_q[cdb_i.rob_id] <= 1'b1;
            if (commit_fire) head_q <= head_q + 1'b1;  // in order
            cnt_q <= cnt_q + (PW+1)'(alloc_valid_i) - (PW+1)'(commit_fire);
        end
    end

    always_ff @(posedge clk_i) begin
        if (cdb_i.valid) val_q[cdb_i.rob_id] <= cdb_i.data;
    end

    assign cdb_off = cdb_i.rob_id - head_q;

    assert property (@(posedge clk_i) disable iff (!rst_n_i) alloc_valid_i |-> !full_o)
        else $error("rob allocation while full");

    // a broadcast must target an entry between head and tail
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cdb_i.valid |-> ((PW+1)'(cdb_off) < cnt_q))
        else $error("cdb marked unallocated rob entry %0d", cdb_i.rob_id);

endmodule

// ==== verification/backend_tb.sv ====
`timescale 1ns/1ps

module backend_tb
    import core_cfg_pkg::*;
    import core_bus_pkg::*;
();

    localparam int MAX_INSTR      = 512;   // room for every instruction of the run
    localparam int ACCEPT_TIMEOUT = 200;   // cycles, per wait
    localparam int DRAIN_TIMEOUT  = 2000;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  in_valid_i;
    instr_t                in_instr_i;
    logic                  in_ready_o;
    logic                  commit_valid_o;
    logic                  commit_ready_i;
    rob_id_t               commit_rob_id_o;
    logic [DATA_WIDTH-1:0] commit_data_o;

    logic [31:0] res_mem [MAX_INSTR];  // model result, indexed by accept order
    logic [31:0] in_exp;               // model result of the presented instruction
    logic [31:0] exp_head;             // oldest uncommitted model result
    int          accept_seq;
    int          commit_seq;
    int          stall_base;           // accept count when commits were stopped
    logic        idle_phase;
    logic        stall_phase;
    logic        hold_commit;
    logic        accept_fire;
    logic        commit_fire;
    int          errors;
    int          timeouts;

    backend_top i_dut (
        .clk_i, .rst_n_i, .in_valid_i, .in_instr_i, .in_ready_o,
        .commit_valid_o, .commit_ready_i, .commit_rob_id_o, .commit_data_o
    );

    always #10 clk_i = ~clk_i;  // 20 ns period

    assign accept_fire = in_valid_i && in_ready_o;
    assign commit_fire = commit_valid_o && commit_ready_i;
    assign exp_head    = res_mem[commit_seq % MAX_INSTR];

    // model bookkeeping at the rising edge
    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            accept_seq <= 0;
            commit_seq <= 0;
        end else begin
            if (accept_fire) begin
                res_mem[accept_seq] <= in_exp;
                accept_seq          <= accept_seq + 1;
            end
            if (commit_fire) commit_seq <= commit_seq + 1;
        end
    end

    // quiet outputs right after reset
    a_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        idle_phase |-> (!commit_valid_o && in_ready_o))
        else begin
            errors++;
            $display("FAILED %0t: commit_valid_o high or in_ready_o low while idle", $time);
        end

    // nothing commits that was never accepted, so each one commits once
    a_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        commit_valid_o |-> (commit_seq < accept_seq))
        else begin
            errors++;
            $display("FAILED %0t: commit offered with no uncommitted instruction", $time);
        end

    a_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        commit_fire |-> (commit_rob_id_o == rob_id_t'(commit_seq % ROB_DEPTH)))
        else begin
            errors++;
            $display("FAILED %0t: commit rob id %0d, expected %0d", $time,
                $sampled(commit_rob_id_o), $sampled(commit_seq) % ROB_DEPTH);
        end

    a_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        commit_fire |-> (commit_data_o == exp_head))
        else begin
            errors++;
            $display("FAILED %0t: commit data %h, expected %h", $time,
                $sampled(commit_data_o), $sampled(exp_head));
        end

    // rob holds at most ROB_DEPTH entries when nothing drains
    a_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_phase && accept_fire) |-> ((accept_seq - stall_base) < ROB_DEPTH))
        else begin
            errors++;
            $display("FAILED %0t: more than %0d accepts with commits held", $time, ROB_DEPTH);
        end

    // opcode rules, operands as 32 bit words
    function automatic logic [31:0] alu_expect(alu_op_e op, logic [31:0] a, logic [31:0] b);
        int sa;
        int sb;
        sa = a;  // int is signed
        sb = b;
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return (sa < sb) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] rand_word();
        case ($urandom_range(7, 0))
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;  // most negative
            2:       return 32'hffff_ffff;
            3:       return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic alu_op_e random_op();
        return alu_op_e'($urandom_range(5, 0));
    endfunction

    // literal or tag to one of the last ROB_DEPTH-1 accepted instructions
    task automatic pick_src(input int dep_pct, output src_t s, output logic [31:0] v);
        int max_d;
        int d;
        max_d   = (accept_seq < ROB_DEPTH - 1) ? accept_seq : ROB_DEPTH - 1;
        s.value = rand_word();
        if (max_d > 0 && $urandom_range(99, 0) < dep_pct) begin
            d = ($urandom_range(1, 0) == 1) ? 1 : $urandom_range(max_d, 1);  // favour back-to-back
            s.is_tag = 1'b1;
            s.tag    = rob_id_t'((accept_seq - d) % ROB_DEPTH);
            v        = res_mem[accept_seq - d];  // producer's model result
        end else begin
            s.is_tag = 1'b0;
            s.tag    = rob_id_t'($urandom);  // don't care for literals
            v        = s.value;
        end
    endtask

    task automatic present(input alu_op_e op, input int dep_pct);
        instr_t      ins;
        logic [31:0] a_v;
        logic [31:0] b_v;
        pick_src(dep_pct, ins.src_a, a_v);
        pick_src(dep_pct, ins.src_b, b_v);
        ins.op     = op;
        in_instr_i = ins;
        in_exp     = alu_expect(op, a_v, b_v);
        in_valid_i = 1'b1;
    endtask

    // falling edge, commit_ready_i gets its next value
    task automatic next_falling();
        @(negedge clk_i);
        if (hold_commit) commit_ready_i = 1'b0;
        else commit_ready_i = ($urandom_range(3, 0) != 0);  // one gap in four
    endtask

    task automatic wait_accept();
        int waited;
        waited = 0;
        while (!in_ready_o && waited < ACCEPT_TIMEOUT) begin
            next_falling();
            waited++;
        end
        if (in_ready_o) begin
            next_falling();  // taken at the rising edge in between
        end else begin
            timeouts++;
            $display("timeout: instruction not accepted within %0d cycles", ACCEPT_TIMEOUT);
        end
        in_valid_i = 1'b0;
    endtask

    initial begin
        int waited;
        void'($urandom(32'h41b918bd));
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        in_valid_i     = 1'b0;
        in_instr_i     = '0;
        in_exp         = '0;
        commit_ready_i = 1'b0;
        idle_phase     = 1'b0;
        stall_phase    = 1'b0;
        hold_commit    = 1'b0;
        stall_base     = 0;
        errors         = 0;
        timeouts       = 0;
        repeat (16) next_falling();
        rst_n_i = 1'b1;

        idle_phase = 1'b1;  // no stimulus yet
        repeat (10) next_falling();
        idle_phase = 1'b0;

        // literal operands, every opcode
        for (int k = 0; k < 8; k++) begin
            for (int op = 0; op < 6; op++) begin
                present(alu_op_e'(op), 0);
                wait_accept();
            end
        end

        // chains and mixed dependences
        for (int k = 0; k < 200; k++) begin
            present(random_op(), 60);
            wait_accept();
            if ($urandom_range(7, 0) == 0) next_falling();  // bubble now and then
        end

        // commits held, rob fills up
        hold_commit    = 1'b1;
        commit_ready_i = 1'b0;
        stall_base     = accept_seq;
        stall_phase    = 1'b1;
        waited         = 0;
        present(random_op(), 50);
        while (in_ready_o && waited < ACCEPT_TIMEOUT) begin
            next_falling();
            waited++;
            present(random_op(), 50);  // last one went in
        end
        if (in_ready_o) begin
            timeouts++;
            $display("timeout: in_ready_o never dropped with commits held");
        end
        repeat (3 * ROB_DEPTH) next_falling();
        stall_phase    = 1'b0;
        hold_commit    = 1'b0;
        commit_ready_i = 1'b1;
        wait_accept();  // instruction held at the input

        for (int k = 0; k < 30; k++) begin
            present(random_op(), 50);
            wait_accept();
        end

        waited = 0;
        while (commit_seq != accept_seq && waited < DRAIN_TIMEOUT) begin
            next_falling();
            waited++;
        end
        if (commit_seq != accept_seq) begin
            timeouts++;
            $display("timeout: %0d accepted instructions never committed",
                accept_seq - commit_seq);
        end
        repeat (5) next_falling();

        $display("accepted %0d, committed %0d, errors %0d, timeouts %0d",
            accept_seq, commit_seq, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
